//--- src/videoPkg.sv
package videoPkg;

	// screen position, wide enough for the full 800x525 raster
	typedef logic [9:0] coordT;

	// 4 bits per channel, packed as {r, g, b}
	typedef logic [11:0] colorT;

	localparam colorT colorBlack  = 12'b0000_0000_0000; // blanking and platforms
	localparam colorT colorRed    = 12'b1111_0000_0000; // lava
	localparam colorT colorGreen  = 12'b0000_1111_0000; // portal
	localparam colorT colorBlue   = 12'b0000_0000_1111; // character
	localparam colorT colorWhite  = 12'b1111_1111_1111; // background after reset
	localparam colorT colorYellow = 12'b1111_1111_0000;
	localparam colorT colorCyan   = 12'b0000_1111_1111;

	// visible window of the 640x480 frame inside the sync counters
	localparam coordT activeLeft   = 10'd144;
	localparam coordT activeRight  = 10'd783;
	localparam coordT activeTop    = 10'd35;
	localparam coordT activeBottom = 10'd515;

endpackage

//--- src/gamePkg.sv
package gamePkg;
	import videoPkg::*;

	typedef enum logic [1:0] {
		level1,
		level2,
		level3
	} levelT;

	typedef enum logic [2:0] {
		moveNone,
		moveRight,
		moveLeft,
		moveUp,
		moveDown
	} moveT;

	typedef enum logic [1:0] {
		zoneNone,
		zonePlatform,
		zoneLava,
		zonePortal
	} zoneKindT;

	typedef struct packed {
		logic valid; // high for one cycle per tick
		moveT move;
	} moveCmdT;

	typedef struct packed {
		zoneKindT kind;
		levelT    target; // only meaningful for portals
	} zoneT;

	typedef struct packed {
		coordT xPos; // centre of the block
		coordT yPos;
		levelT level;
	} avatarT;

	// inclusive bounds on both axes
	typedef struct packed {
		coordT xMin;
		coordT xMax;
		coordT yMin;
		coordT yMax;
	} rectT;

	localparam int numLevels    = 3;
	localparam int maxPlatforms = 6;
	localparam int maxLava      = 1;
	localparam int maxPortals   = 2;

	localparam coordT moveStep  = 10'd2;
	localparam coordT wrapXHigh = 10'd800; // right edge, jumps to wrapXLow
	localparam coordT wrapXLow  = 10'd150;
	localparam coordT wrapYHigh = 10'd514; // bottom edge, jumps to wrapYLow
	localparam coordT wrapYLow  = 10'd34;

	localparam coordT resetX     = 10'd450;
	localparam coordT resetY     = 10'd250;
	localparam coordT avatarHalf = 10'd5; // 11x11 pixel box

	// spawn points sit in open space, clear of lava and portals
	localparam coordT spawnX [numLevels] = '{10'd450, 10'd200, 10'd464};
	localparam coordT spawnY [numLevels] = '{10'd250, 10'd194, 10'd100};

	// min above max can never match
	localparam rectT emptyRect = '{10'd1023, 10'd0, 10'd1023, 10'd0};

	localparam rectT platformRects [numLevels][maxPlatforms] = '{
		'{ // level 1
			'{activeLeft, 10'd400, 10'd259, activeBottom},
			'{activeLeft, 10'd208, activeTop, 10'd258},
			'{10'd209, activeRight, activeTop, 10'd155},
			'{10'd639, activeRight, 10'd156, 10'd203},
			'{10'd703, activeRight, 10'd268, 10'd427},
			'{10'd561, activeRight, 10'd387, activeBottom}
		},
		'{ // level 2
			'{activeLeft, 10'd400, 10'd227, activeBottom},
			'{activeLeft, 10'd400, activeTop, 10'd163},
			'{10'd529, 10'd656, activeTop, 10'd163},
			'{10'd529, 10'd656, 10'd227, activeBottom},
			'{10'd655, activeRight, 10'd268, 10'd427},
			'{10'd719, activeRight, activeTop, 10'd323}
		},
		'{ // level 3, two walls around a shaft
			'{activeLeft, 10'd400, activeTop, activeBottom},
			'{10'd529, activeRight, activeTop, activeBottom},
			emptyRect,
			emptyRect,
			emptyRect,
			emptyRect
		}
	};

	localparam rectT lavaRects [numLevels][maxLava] = '{
		'{'{10'd401, 10'd560, 10'd387, activeBottom}},
		'{'{10'd401, 10'd528, activeTop, 10'd67}},
		'{'{10'd448, 10'd480, 10'd355, 10'd467}}
	};

	localparam rectT portalRects [numLevels][maxPortals] = '{
		'{'{10'd767, activeRight, 10'd204, 10'd267}, emptyRect},
		'{
			'{activeLeft, 10'd160, 10'd164, 10'd226},
			'{10'd401, 10'd528, 10'd499, activeBottom}
		},
		'{'{10'd401, 10'd528, activeTop, 10'd51}, emptyRect}
	};

	// destination for each portal slot above
	localparam levelT portalTarget [numLevels][maxPortals] = '{
		'{level2, level1},
		'{level1, level3},
		'{level2, level1}
	};

endpackage

//--- src/zoneLookup.sv
`timescale 1ns/1ps

module zoneLookup
	import videoPkg::*;
	import gamePkg::*;
(
	input  levelT level,
	input  coordT xPos,
	input  coordT yPos,
	output zoneT  zone
);

	function automatic logic inRect(input rectT r, input coordT x, input coordT y);
		return (x >= r.xMin) && (x <= r.xMax) && (y >= r.yMin) && (y <= r.yMax);
	endfunction

	logic hitPlatform;
	logic hitLava;
	logic hitPortal;
	levelT portalDest;

	always_comb begin
		hitPlatform = 1'b0;
		for (int i = 0; i < maxPlatforms; i++) begin
			if (inRect(platformRects[level][i], xPos, yPos)) begin
				hitPlatform = 1'b1;
			end
		end
	end

	always_comb begin
		hitLava = 1'b0;
		for (int i = 0; i < maxLava; i++) begin
			if (inRect(lavaRects[level][i], xPos, yPos)) begin
				hitLava = 1'b1;
			end
		end
	end

	// portals never overlap, so the last match is the only match
	always_comb begin
		hitPortal  = 1'b0;
		portalDest = level1;
		for (int i = 0; i < maxPortals; i++) begin
			if (inRect(portalRects[level][i], xPos, yPos)) begin
				hitPortal  = 1'b1;
				portalDest = portalTarget[level][i];
			end
		end
	end

	always_comb begin
		zone.target = portalDest;
		if (hitLava) begin // lava beats everything
			zone.kind = zoneLava;
		end else if (hitPortal) begin
			zone.kind = zonePortal;
		end else if (hitPlatform) begin
			zone.kind = zonePlatform;
		end else begin
			zone.kind = zoneNone;
		end
	end

endmodule

//--- src/moveDecode.sv
`timescale 1ns/1ps

module moveDecode
	import videoPkg::*;
	import gamePkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  logic    moveTick,
	input  logic    right,
	input  logic    left,
	input  logic    up,
	input  logic    down,
	output moveCmdT moveCmd,
	output colorT   background
);

	moveT pick;

	always_comb begin
		if (right) begin // right wins over everything
			pick = moveRight;
		end else if (left) begin
			pick = moveLeft;
		end else if (up) begin
			pick = moveUp;
		end else if (down) begin
			pick = moveDown;
		end else begin
			pick = moveNone;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			moveCmd    <= '{valid: 1'b0, move: moveNone};
			background <= colorWhite;
		end else begin
			moveCmd.valid <= moveTick; // one-cycle strobe per tick
			if (moveTick) begin
				moveCmd.move <= pick;
				case (pick)
					moveRight: background <= colorYellow;
					moveLeft:  background <= colorCyan;
					moveUp:    background <= colorGreen;
					moveDown:  background <= colorBlue;
					default:   background <= background; // idle keeps last colour
				endcase
			end
		end
	end

endmodule

//--- src/avatarMotion.sv
`timescale 1ns/1ps

module avatarMotion
	import videoPkg::*;
	import gamePkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  moveCmdT moveCmd,
	output avatarT  avatar
);

	zoneT   here;
	avatarT stepped;

	// hazard seen at the current centre, acted on at the next command
	zoneLookup uZone (
		.level(avatar.level),
		.xPos (avatar.xPos),
		.yPos (avatar.yPos),
		.zone (here)
	);

	// plain move with screen wrap
	always_comb begin
		stepped = avatar;
		case (moveCmd.move)
			moveRight: begin
				stepped.xPos = (avatar.xPos == wrapXHigh) ? wrapXLow : avatar.xPos + moveStep;
			end
			moveLeft: begin
				stepped.xPos = (avatar.xPos == wrapXLow) ? wrapXHigh : avatar.xPos - moveStep;
			end
			moveUp: begin
				stepped.yPos = (avatar.yPos == wrapYLow) ? wrapYHigh : avatar.yPos - moveStep;
			end
			moveDown: begin
				stepped.yPos = (avatar.yPos == wrapYHigh) ? wrapYLow : avatar.yPos + moveStep;
			end
			default: begin
				stepped = avatar; // moveNone holds still
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			avatar <= '{xPos: resetX, yPos: resetY, level: level1};
		end else if (moveCmd.valid) begin
			if (here.kind == zoneLava) begin
				avatar.xPos <= spawnX[avatar.level]; // back to start, same level
				avatar.yPos <= spawnY[avatar.level];
			end else if (here.kind == zonePortal) begin
				avatar.level <= here.target;
				avatar.xPos  <= spawnX[here.target];
				avatar.yPos  <= spawnY[here.target];
			end else begin
				avatar <= stepped; // platforms do not block
			end
		end
	end

endmodule

//--- src/pixelShader.sv
`timescale 1ns/1ps

module pixelShader
	import videoPkg::*;
	import gamePkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  coordT  hCount,
	input  coordT  vCount,
	input  logic   bright,
	input  avatarT avatar,
	input  colorT  background,
	output colorT  rgb
);

	zoneT  pixZone;
	logic  inBox;
	colorT rgbNext;

	zoneLookup uZone (
		.level(avatar.level),
		.xPos (hCount),
		.yPos (vCount),
		.zone (pixZone)
	);

	// square of side 2*avatarHalf+1 around the centre
	assign inBox = (hCount >= avatar.xPos - avatarHalf) && (hCount <= avatar.xPos + avatarHalf)
		&& (vCount >= avatar.yPos - avatarHalf) && (vCount <= avatar.yPos + avatarHalf);

	always_comb begin
		if (!bright) begin
			rgbNext = colorBlack; // monitor expects black during blanking
		end else if (inBox) begin
			rgbNext = colorBlue;
		end else if (pixZone.kind == zoneLava) begin
			rgbNext = colorRed;
		end else if (pixZone.kind == zonePortal) begin
			rgbNext = colorGreen;
		end else if (pixZone.kind == zonePlatform) begin
			rgbNext = colorBlack;
		end else begin
			rgbNext = background;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rgb <= colorBlack;
		end else begin
			rgb <= rgbNext; // one cycle behind the counters
		end
	end

endmodule

//--- src/platformerTop.sv
`timescale 1ns/1ps

module platformerTop
	import videoPkg::*;
	import gamePkg::*;
(
	input  logic   clk,
	input  logic   rst,
	input  logic   moveTick,
	input  logic   right,
	input  logic   left,
	input  logic   up,
	input  logic   down,
	input  coordT  hCount,
	input  coordT  vCount,
	input  logic   bright,
	output colorT  rgb,
	output colorT  background,
	output avatarT avatar
);

	moveCmdT moveCmd;

	moveDecode uDecode (
		.clk       (clk),
		.rst       (rst),
		.moveTick  (moveTick),
		.right     (right),
		.left      (left),
		.up        (up),
		.down      (down),
		.moveCmd   (moveCmd),
		.background(background)
	);

	avatarMotion uMotion (
		.clk    (clk),
		.rst    (rst),
		.moveCmd(moveCmd),
		.avatar (avatar)
	);

	pixelShader uShader (
		.clk       (clk),
		.rst       (rst),
		.hCount    (hCount),
		.vCount    (vCount),
		.bright    (bright),
		.avatar    (avatar),
		.background(background),
		.rgb       (rgb)
	);

endmodule

//--- dv/platformerTb.sv
`timescale 1ns/1ps

module platformerTb
	import videoPkg::*;
	import gamePkg::*;
();

	localparam int cycleLimit = 20000; // all tests need roughly 4.4k cycles

	logic   clk;
	logic   rst;
	logic   moveTick;
	logic   right;
	logic   left;
	logic   up;
	logic   down;
	coordT  hCount;
	coordT  vCount;
	logic   bright;
	colorT  rgb;
	colorT  background;
	avatarT avatar;

	coordT mX; // reference model state
	coordT mY;
	levelT mLevel;
	colorT mBg;

	int errors;
	int checks;
	int testsRun;
	int cycleCount = 0;
	logic [31:0] seed;

	platformerTop UUT (
		.clk       (clk),
		.rst       (rst),
		.moveTick  (moveTick),
		.right     (right),
		.left      (left),
		.up        (up),
		.down      (down),
		.hCount    (hCount),
		.vCount    (vCount),
		.bright    (bright),
		.rgb       (rgb),
		.background(background),
		.avatar    (avatar)
	);

	always #10 clk = ~clk; // 20 ns period

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, the tests did not finish", cycleCount);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH %s: got %h, expected %h", name, got, exp);
		end
	endtask

	function automatic logic [31:0] nextRandom();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic logic contains(input rectT r, input coordT x, input coordT y);
		return (x >= r.xMin) && (x <= r.xMax) && (y >= r.yMin) && (y <= r.yMax);
	endfunction

	// later loops override earlier ones: lava over portal over platform
	function automatic zoneKindT zoneAt(input levelT lv, input coordT x, input coordT y,
		output levelT dest);
		zoneKindT kind;
		kind = zoneNone;
		dest = level1;
		for (int i = 0; i < maxPlatforms; i++) begin
			if (contains(platformRects[lv][i], x, y)) kind = zonePlatform;
		end
		for (int i = 0; i < maxPortals; i++) begin
			if (contains(portalRects[lv][i], x, y)) begin
				kind = zonePortal;
				dest = portalTarget[lv][i];
			end
		end
		for (int i = 0; i < maxLava; i++) begin
			if (contains(lavaRects[lv][i], x, y)) kind = zoneLava;
		end
		return kind;
	endfunction

	// btn is {right, left, up, down}
	task automatic modelTick(input logic [3:0] btn);
		moveT     mv;
		zoneKindT kind;
		levelT    dest;
		if (btn[3]) mv = moveRight;
		else if (btn[2]) mv = moveLeft;
		else if (btn[1]) mv = moveUp;
		else if (btn[0]) mv = moveDown;
		else mv = moveNone;
		case (mv)
			moveRight: mBg = colorYellow;
			moveLeft:  mBg = colorCyan;
			moveUp:    mBg = colorGreen;
			moveDown:  mBg = colorBlue;
			default:   mBg = mBg;
		endcase
		kind = zoneAt(mLevel, mX, mY, dest); // hazard at the position before the move
		if (kind == zoneLava) begin
			mX = spawnX[mLevel];
			mY = spawnY[mLevel];
		end else if (kind == zonePortal) begin
			mLevel = dest;
			mX = spawnX[dest];
			mY = spawnY[dest];
		end else begin
			case (mv)
				moveRight: mX = (mX == wrapXHigh) ? wrapXLow : mX + moveStep;
				moveLeft:  mX = (mX == wrapXLow) ? wrapXHigh : mX - moveStep;
				moveUp:    mY = (mY == wrapYLow) ? wrapYHigh : mY - moveStep;
				moveDown:  mY = (mY == wrapYHigh) ? wrapYLow : mY + moveStep;
				default:   mX = mX;
			endcase
		end
	endtask

	function automatic colorT modelPixel(input coordT h, input coordT v, input logic br);
		levelT    dest;
		zoneKindT kind;
		kind = zoneAt(mLevel, h, v, dest);
		if (!br) return colorBlack;
		if (h >= mX - avatarHalf && h <= mX + avatarHalf
			&& v >= mY - avatarHalf && v <= mY + avatarHalf) return colorBlue;
		if (kind == zoneLava) return colorRed;
		if (kind == zonePortal) return colorGreen;
		if (kind == zonePlatform) return colorBlack;
		return mBg;
	endfunction

	task automatic resetDut();
		@(posedge clk);
		rst      <= 1'b1;
		moveTick <= 1'b0;
		{right, left, up, down} <= 4'b0000;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		mX     = resetX;
		mY     = resetY;
		mLevel = level1;
		mBg    = colorWhite;
	endtask

	task automatic checkAvatar();
		checkValue("avatar.xPos", 32'(avatar.xPos), 32'(mX));
		checkValue("avatar.yPos", 32'(avatar.yPos), 32'(mY));
		checkValue("avatar.level", 32'(avatar.level), 32'(mLevel));
		checkValue("background", 32'(background), 32'(mBg));
	endtask

	task automatic expectPos(input coordT x, input coordT y, input levelT lv);
		checkValue("avatar.xPos", 32'(avatar.xPos), 32'(x));
		checkValue("avatar.yPos", 32'(avatar.yPos), 32'(y));
		checkValue("avatar.level", 32'(avatar.level), 32'(lv));
	endtask

	task automatic applyTick(input logic [3:0] btn);
		@(posedge clk);
		{right, left, up, down} <= btn;
		moveTick <= 1'b1;
		@(posedge clk); // decode samples the tick here
		moveTick <= 1'b0;
		@(posedge clk); // avatar updates here
		modelTick(btn);
		@(negedge clk);
		checkAvatar();
	endtask

	task automatic steer(input logic [3:0] btn, input int count);
		repeat (count) applyTick(btn);
	endtask

	task automatic probePixel(input coordT h, input coordT v, input logic br);
		@(posedge clk);
		hCount <= h;
		vCount <= v;
		bright <= br;
		@(posedge clk);
		@(negedge clk); // rgb is one cycle behind
		checkValue("rgb", 32'(rgb), 32'(modelPixel(h, v, br)));
	endtask

	task automatic reportTest(input string name, input int startErrors);
		testsRun++;
		$display("test %0d %s: %0d errors", testsRun, name, errors - startErrors);
	endtask

	task automatic testReset();
		int startErrors;
		startErrors = errors;
		resetDut();
		@(negedge clk);
		expectPos(10'd450, 10'd250, level1);
		checkValue("background", 32'(background), 32'(colorWhite));
		checkValue("rgb", 32'(rgb), 32'(colorBlack));
		probePixel(10'd450, 10'd250, 1'b0);
		probePixel(10'd450, 10'd450, 1'b0);
		probePixel(10'd775, 10'd230, 1'b0);
		reportTest("reset state", startErrors);
	endtask

	task automatic testDecodeWrap();
		int startErrors;
		startErrors = errors;
		resetDut();
		applyTick(4'b1111); // right beats all
		checkValue("background", 32'(background), 32'(colorYellow));
		applyTick(4'b0111);
		checkValue("background", 32'(background), 32'(colorCyan));
		applyTick(4'b0011);
		checkValue("background", 32'(background), 32'(colorGreen));
		applyTick(4'b0001);
		checkValue("background", 32'(background), 32'(colorBlue));
		applyTick(4'b0000); // no button keeps colour and position
		expectPos(10'd450, 10'd250, level1);
		steer(4'b0100, 150);
		expectPos(10'd150, 10'd250, level1);
		applyTick(4'b0100);
		expectPos(10'd800, 10'd250, level1);
		applyTick(4'b0100);
		applyTick(4'b1000);
		expectPos(10'd800, 10'd250, level1);
		applyTick(4'b1000);
		expectPos(10'd150, 10'd250, level1);
		steer(4'b0010, 108);
		expectPos(10'd150, 10'd34, level1);
		applyTick(4'b0010);
		expectPos(10'd150, 10'd514, level1);
		applyTick(4'b0001);
		expectPos(10'd150, 10'd34, level1);
		applyTick(4'b0001);
		reportTest("decode and wrap", startErrors);
	endtask

	task automatic testPixelPriority();
		int startErrors;
		startErrors = errors;
		resetDut();
		applyTick(4'b0100); // background cyan, avatar at 448
		probePixel(10'd450, 10'd252, 1'b1); // avatar box
		probePixel(10'd450, 10'd450, 1'b1); // lava
		probePixel(10'd775, 10'd230, 1'b1); // portal
		probePixel(10'd300, 10'd400, 1'b1); // platform
		probePixel(10'd450, 10'd200, 1'b1);
		checkValue("rgb", 32'(rgb), 32'(colorCyan));
		probePixel(10'd450, 10'd250, 1'b0); // blanking
		reportTest("pixel priority", startErrors);
	endtask

	task automatic testPortalTravel();
		int startErrors;
		startErrors = errors;
		resetDut();
		steer(4'b1000, 159); // into the level 1 portal
		applyTick(4'b0000);
		expectPos(spawnX[level2], spawnY[level2], level2);
		steer(4'b1000, 101);
		steer(4'b0001, 153); // bottom portal of level 2
		applyTick(4'b0000);
		expectPos(spawnX[level3], spawnY[level3], level3);
		steer(4'b0010, 25);
		applyTick(4'b0000);
		expectPos(spawnX[level2], spawnY[level2], level2);
		steer(4'b0100, 20); // left portal back home
		applyTick(4'b0000);
		expectPos(spawnX[level1], spawnY[level1], level1);
		reportTest("portal travel", startErrors);
	endtask

	task automatic testLavaRespawn();
		int startErrors;
		startErrors = errors;
		resetDut();
		steer(4'b0001, 69);
		expectPos(10'd450, 10'd388, level1);
		applyTick(4'b1000); // hazard wins over the button
		expectPos(spawnX[level1], spawnY[level1], level1);
		steer(4'b1000, 160); // through the portal into level 2
		expectPos(spawnX[level2], spawnY[level2], level2);
		steer(4'b1000, 101);
		steer(4'b0010, 64); // up into the level 2 lava
		expectPos(10'd402, 10'd66, level2);
		applyTick(4'b0010);
		expectPos(spawnX[level2], spawnY[level2], level2);
		reportTest("lava respawn", startErrors);
	endtask

	task automatic testRandomWalk();
		int startErrors;
		logic [31:0] r;
		startErrors = errors;
		resetDut();
		repeat (300) begin
			r = nextRandom();
			applyTick(r[27:24]);
		end
		reportTest("random walk", startErrors);
	endtask

	initial begin
		clk      = 1'b0;
		rst      <= 1'b1;
		moveTick <= 1'b0;
		right    <= 1'b0;
		left     <= 1'b0;
		up       <= 1'b0;
		down     <= 1'b0;
		hCount   <= '0;
		vCount   <= '0;
		bright   <= 1'b0;
		errors   = 0;
		checks   = 0;
		testsRun = 0;
		seed     = 32'h8166_0941;
		testReset();
		testDecodeWrap();
		testPixelPriority();
		testPortalTravel();
		testLavaRespawn();
		testRandomWalk();
		$display("%0d tests, %0d checks, %0d errors", testsRun, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- platformerTop.f
src/videoPkg.sv
src/gamePkg.sv
src/zoneLookup.sv
src/moveDecode.sv
src/avatarMotion.sv
src/pixelShader.sv
src/platformerTop.sv
dv/platformerTb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	--top-module platformerTb -f platformerTop.f

simOutput=$(./obj_dir/VplatformerTb)
echo "$simOutput"

if echo "$simOutput" | grep -qx "Verification passed"; then
	exit 0
else
	exit 1
fi
